//--- build.f
logic/bus_pkg.sv
logic/map_pkg.sv
logic/bus_arbiter.sv
logic/bus_decoder.sv
logic/block_ram.sv
logic/dma_engine.sv
logic/soc_bus.sv
tests/soc_bus_chk.sv
tests/soc_bus_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the soc_bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_bus_tb -f build.f

# Let assertion failures be counted so the testbench reaches its summary
out=$(./obj_dir/Vsoc_bus_tb +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -q "ALL TESTS PASSED"

//--- tests/soc_bus_tb.sv
`default_nettype none

module soc_bus_tb;

	import bus_pkg::*;
	import map_pkg::*;

	localparam int RAM_WORDS   = 512;
	localparam int DRIVE_DELAY = 10;
	localparam int WAIT_LIMIT  = 200;
	localparam int POLL_LIMIT  = 100;
	localparam int SRC_WORD    = 64;
	localparam int DST_WORD    = 128;
	localparam int COPY_WORDS  = 4;
	localparam int SRC2_WORD   = 80;
	localparam int DST2_WORD   = 144;
	localparam int GUARD_WORDS = 2;
	localparam logic [31:0] UNMAPPED_ADDR = 32'h5000_0010;

	logic      clock;
	logic      i_rst_n;
	logic      i_a_req;
	bus_addr_t i_a_addr;
	logic      o_a_ack;
	bus_rsp_t  o_a_rsp;
	logic      i_b_req;
	bus_req_t  i_b_cmd;
	logic      o_b_ack;
	bus_rsp_t  o_b_rsp;

	// Expected RAM contents, one entry per word written
	logic [31:0] model [RAM_WORDS];
	int          seed;
	string       test_name;
	int          fail_count;
	int          fails_at_start;
	int          tests_passed;
	int          tests_failed;

	soc_bus #(
		.RAM_WORDS (RAM_WORDS)
	) dut (
		.clock    (clock),
		.i_rst_n  (i_rst_n),
		.i_a_req  (i_a_req),
		.i_a_addr (i_a_addr),
		.o_a_ack  (o_a_ack),
		.o_a_rsp  (o_a_rsp),
		.i_b_req  (i_b_req),
		.i_b_cmd  (i_b_cmd),
		.o_b_ack  (o_b_ack),
		.o_b_rsp  (o_b_rsp)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] ram_addr(input int word);
		ram_addr = {region_ram, 28'(word * 4)};
	endfunction

	function automatic logic [31:0] reg_addr(input logic [1:0] idx);
		reg_addr = {region_dma, 24'd0, idx, 2'b00};
	endfunction

	// Testbench checks plus bound handshake assertions
	function automatic int total_fails();
		total_fails = fail_count + dut.u_chk.assert_fails;
	endfunction

	task automatic check_word(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("** Error %s (%s): expected %h, actual %h",
				test_name, what, expected, actual);
			fail_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name      = name;
		fails_at_start = total_fails();
	endtask

	task automatic finish_test();
		if (total_fails() == fails_at_start)
		begin
			$display("Test %s: passed", test_name);
			tests_passed++;
		end
		else
		begin
			$display("Test %s: failed", test_name);
			tests_failed++;
		end
	endtask

	// Waits resume at the drive point after a rising edge
	task automatic wait_a_ack(input logic level);
		int cycles;
		cycles = 0;
		while (o_a_ack !== level && cycles < WAIT_LIMIT)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
			cycles++;
		end
		assert (o_a_ack === level)
		else
		begin
			$display("Timeout in %s: port a ack never went to %0b", test_name, level);
			fail_count++;
		end
	endtask

	task automatic wait_b_ack(input logic level);
		int cycles;
		cycles = 0;
		while (o_b_ack !== level && cycles < WAIT_LIMIT)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
			cycles++;
		end
		assert (o_b_ack === level)
		else
		begin
			$display("Timeout in %s: port b ack never went to %0b", test_name, level);
			fail_count++;
		end
	endtask

	// ====================
	// Four-phase transfers
	// ====================

	task automatic transfer_b(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		i_b_cmd.write    = wr;
		i_b_cmd.addr.raw = addr;
		i_b_cmd.wdata    = wdata;
		i_b_req          = 1'b1;
		wait_b_ack(1'b1);
		rdata   = o_b_rsp.rdata;
		i_b_req = 1'b0;
		wait_b_ack(1'b0);
	endtask

	task automatic bus_write_b(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] ignored;
		transfer_b(1'b1, addr, wdata, ignored);
	endtask

	task automatic bus_read_b(input logic [31:0] addr, output logic [31:0] rdata);
		transfer_b(1'b0, addr, 32'd0, rdata);
	endtask

	task automatic bus_read_a(input logic [31:0] addr, output logic [31:0] rdata);
		i_a_addr.raw = addr;
		i_a_req      = 1'b1;
		wait_a_ack(1'b1);
		rdata   = o_a_rsp.rdata;
		i_a_req = 1'b0;
		wait_a_ack(1'b0);
	endtask

	task automatic wait_dma_idle();
		logic [31:0] ctrl;
		int          polls;
		polls = 0;
		bus_read_b(reg_addr(dma_reg_ctrl), ctrl);
		while (ctrl[ctrl_busy_bit] && polls < POLL_LIMIT)
		begin
			bus_read_b(reg_addr(dma_reg_ctrl), ctrl);
			polls++;
		end
		assert (!ctrl[ctrl_busy_bit])
		else
		begin
			$display("Timeout in %s: DMA still busy after %0d polls", test_name, polls);
			fail_count++;
		end
	endtask

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		logic [31:0] data;
		logic [31:0] data_a;
		logic [31:0] data_b;
		int          total;

		seed         = 32'hac85;
		fail_count   = 0;
		tests_passed = 0;
		tests_failed = 0;
		i_rst_n      = 1'b0;
		i_a_req      = 1'b0;
		i_a_addr     = '0;
		i_b_req      = 1'b0;
		i_b_cmd      = '0;
		repeat (5) @(posedge clock);
		#DRIVE_DELAY;
		i_rst_n = 1'b1;
		@(posedge clock);
		#DRIVE_DELAY;

		start_test("ram_write_read");
		for (int i = 0; i < 8; i++)
		begin
			model[i] = $random(seed);
			bus_write_b(ram_addr(i), model[i]);
		end
		for (int i = 0; i < 8; i++)
		begin
			bus_read_b(ram_addr(i), data);
			check_word("port b read", model[i], data);
		end
		finish_test();

		start_test("fetch_port_read");
		for (int i = 0; i < 8; i++)
		begin
			bus_read_a(ram_addr(i), data);
			check_word("port a read", model[i], data);
		end
		finish_test();

		start_test("unmapped_region");
		bus_write_b(UNMAPPED_ADDR, $random(seed));
		bus_read_b(UNMAPPED_ADDR, data);
		check_word("region 5 read", 32'd0, data);
		finish_test();

		// Both ports request in the same cycle
		start_test("contention");
		for (int i = 0; i < 3; i++)
		begin
			fork
				bus_read_a(ram_addr(i), data_a);
				bus_read_b(ram_addr(i + 4), data_b);
			join
			check_word("port a read", model[i], data_a);
			check_word("port b read", model[i + 4], data_b);
		end
		finish_test();

		start_test("dma_copy");
		for (int i = 0; i < COPY_WORDS; i++)
		begin
			model[SRC_WORD + i] = $random(seed);
			bus_write_b(ram_addr(SRC_WORD + i), model[SRC_WORD + i]);
		end
		bus_write_b(reg_addr(dma_reg_src), ram_addr(SRC_WORD));
		bus_write_b(reg_addr(dma_reg_dst), ram_addr(DST_WORD));
		bus_write_b(reg_addr(dma_reg_count), 32'(COPY_WORDS));
		bus_write_b(reg_addr(dma_reg_ctrl), 32'd1 << ctrl_start_bit);
		// Three masters on the bus while the copy runs
		for (int i = 0; i < 4; i++)
		begin
			fork
				bus_read_a(ram_addr(i + 4), data_a);
				bus_read_b(ram_addr(i), data_b);
			join
			check_word("port a read during copy", model[i + 4], data_a);
			check_word("port b read during copy", model[i], data_b);
		end
		wait_dma_idle();
		for (int i = 0; i < COPY_WORDS; i++)
		begin
			model[DST_WORD + i] = model[SRC_WORD + i];
			bus_read_a(ram_addr(DST_WORD + i), data);
			check_word("copied word", model[DST_WORD + i], data);
		end
		finish_test();

		start_test("dma_register_guard");
		for (int i = 0; i < GUARD_WORDS; i++)
		begin
			model[SRC2_WORD + i] = $random(seed);
			bus_write_b(ram_addr(SRC2_WORD + i), model[SRC2_WORD + i]);
		end
		bus_write_b(reg_addr(dma_reg_src), ram_addr(SRC2_WORD));
		bus_write_b(reg_addr(dma_reg_dst), ram_addr(DST2_WORD));
		bus_write_b(reg_addr(dma_reg_count), 32'(GUARD_WORDS));
		bus_write_b(reg_addr(dma_reg_ctrl), 32'd1 << ctrl_start_bit);
		bus_read_b(reg_addr(dma_reg_ctrl), data);
		check_word("busy after start", 32'd1, {31'd0, data[ctrl_busy_bit]});
		// Would lengthen the copy if accepted
		bus_write_b(reg_addr(dma_reg_count), 32'd9);
		wait_dma_idle();
		bus_read_b(reg_addr(dma_reg_count), data);
		check_word("count after copy", 32'd0, data);
		bus_read_b(reg_addr(dma_reg_src), data);
		check_word("src after copy", ram_addr(SRC2_WORD + GUARD_WORDS), data);
		bus_read_b(reg_addr(dma_reg_dst), data);
		check_word("dst after copy", ram_addr(DST2_WORD + GUARD_WORDS), data);
		for (int i = 0; i < GUARD_WORDS; i++)
		begin
			bus_read_b(ram_addr(DST2_WORD + i), data);
			check_word("copied word", model[SRC2_WORD + i], data);
		end
		finish_test();

		total = total_fails();
		$display("Tests: %0d passed, %0d failed, %0d check failures",
			tests_passed, tests_failed, total);
		if (tests_failed == 0 && total == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/soc_bus_chk.sv
`default_nettype none

// Link bit order in the req and ack vectors:
// a, b, dma master, downstream bus, ram slave, dma registers
module soc_bus_chk (
	input wire                     clock,
	input wire                     i_rst_n,
	input wire [2:0]               i_grant,
	input wire [5:0]               i_reqs,
	input wire [5:0]               i_acks,
	input wire bus_pkg::bus_addr_t i_a_addr,
	input wire bus_pkg::bus_req_t  i_b_cmd,
	input wire bus_pkg::bus_req_t  i_c_cmd,
	input wire bus_pkg::bus_req_t  i_bus_cmd
);

	int assert_fails = 0;

	// ====================
	// Arbitration
	// ====================

	grant_onehot: assert property (@(posedge clock) disable iff (!i_rst_n)
		$onehot0(i_grant))
	else
	begin
		$error("arbiter grant is not one-hot: %b", i_grant);
		assert_fails++;
	end

	// ====================
	// Four-phase handshake
	// ====================

	// A new ack answers the req seen at the edge before
	ack_needs_req: assert property (@(posedge clock) disable iff (!i_rst_n)
		((i_acks & ~$past(i_acks)) & ~$past(i_reqs)) == 6'd0)
	else
	begin
		$error("ack rose without req, acks %b reqs %b", i_acks, i_reqs);
		assert_fails++;
	end

	req_after_ack: assert property (@(posedge clock) disable iff (!i_rst_n)
		((i_reqs & ~$past(i_reqs)) & i_acks) == 6'd0)
	else
	begin
		$error("req rose while ack high, acks %b reqs %b", i_acks, i_reqs);
		assert_fails++;
	end

	// Command held from req until ack
	a_addr_stable: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_reqs[5] && !i_acks[5] |=> !i_reqs[5] || $stable(i_a_addr))
	else
	begin
		$error("port a address changed while waiting for ack");
		assert_fails++;
	end

	b_cmd_stable: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_reqs[4] && !i_acks[4] |=> !i_reqs[4] || $stable(i_b_cmd))
	else
	begin
		$error("port b command changed while waiting for ack");
		assert_fails++;
	end

	c_cmd_stable: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_reqs[3] && !i_acks[3] |=> !i_reqs[3] || $stable(i_c_cmd))
	else
	begin
		$error("DMA command changed while waiting for ack");
		assert_fails++;
	end

	bus_cmd_stable: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_reqs[2] && !i_acks[2] |=> !i_reqs[2] || $stable(i_bus_cmd))
	else
	begin
		$error("downstream command changed while waiting for ack");
		assert_fails++;
	end

endmodule

bind soc_bus soc_bus_chk u_chk (
	.clock     (clock),
	.i_rst_n   (i_rst_n),
	.i_grant   (u_arbiter.grant),
	.i_reqs    ({i_a_req, i_b_req, dma_req, bus_req, ram_req, dma_reg_req}),
	.i_acks    ({o_a_ack, o_b_ack, dma_ack, bus_ack, ram_ack, dma_reg_ack}),
	.i_a_addr  (i_a_addr),
	.i_b_cmd   (i_b_cmd),
	.i_c_cmd   (dma_cmd),
	.i_bus_cmd (bus_cmd)
);

`default_nettype wire

//--- logic/soc_bus.sv
`default_nettype none

module soc_bus #(
	parameter int RAM_WORDS = 512
) (
	input  wire                 clock,
	input  wire                 i_rst_n,
	input  wire                 i_a_req,
	input  wire bus_pkg::bus_addr_t i_a_addr,
	output logic                o_a_ack,
	output bus_pkg::bus_rsp_t   o_a_rsp,
	input  wire                 i_b_req,
	input  wire bus_pkg::bus_req_t  i_b_cmd,
	output logic                o_b_ack,
	output bus_pkg::bus_rsp_t   o_b_rsp
);

	import bus_pkg::*;

	// Shared bus, arbiter to decoder
	logic     bus_req;
	bus_req_t bus_cmd;
	logic     bus_ack;
	bus_rsp_t bus_rsp;

	// Decoder to slaves
	bus_req_t slave_cmd;
	logic     ram_req;
	logic     ram_ack;
	bus_rsp_t ram_rsp;
	logic     dma_reg_req;
	logic     dma_reg_ack;
	bus_rsp_t dma_reg_rsp;

	// DMA master port
	logic     dma_req;
	bus_req_t dma_cmd;
	logic     dma_ack;
	bus_rsp_t dma_rsp;

	// ====================
	// Arbitration
	// ====================

	bus_arbiter u_arbiter (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_a_req   (i_a_req),
		.i_a_addr  (i_a_addr),
		.o_a_ack   (o_a_ack),
		.o_a_rsp   (o_a_rsp),
		.i_b_req   (i_b_req),
		.i_b_cmd   (i_b_cmd),
		.o_b_ack   (o_b_ack),
		.o_b_rsp   (o_b_rsp),
		.i_c_req   (dma_req),
		.i_c_cmd   (dma_cmd),
		.o_c_ack   (dma_ack),
		.o_c_rsp   (dma_rsp),
		.o_bus_req (bus_req),
		.o_bus_cmd (bus_cmd),
		.i_bus_ack (bus_ack),
		.i_bus_rsp (bus_rsp)
	);

	bus_decoder u_decoder (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_req     (bus_req),
		.i_cmd     (bus_cmd),
		.o_ack     (bus_ack),
		.o_rsp     (bus_rsp),
		.o_ram_req (ram_req),
		.i_ram_ack (ram_ack),
		.i_ram_rsp (ram_rsp),
		.o_dma_req (dma_reg_req),
		.i_dma_ack (dma_reg_ack),
		.i_dma_rsp (dma_reg_rsp),
		.o_cmd     (slave_cmd)
	);

	// ====================
	// Slaves
	// ====================

	block_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (ram_req),
		.i_cmd   (slave_cmd),
		.o_ack   (ram_ack),
		.o_rsp   (ram_rsp)
	);

	dma_engine u_dma (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_reg_req (dma_reg_req),
		.i_reg_cmd (slave_cmd),
		.o_reg_ack (dma_reg_ack),
		.o_reg_rsp (dma_reg_rsp),
		.o_bus_req (dma_req),
		.o_bus_cmd (dma_cmd),
		.i_bus_ack (dma_ack),
		.i_bus_rsp (dma_rsp)
	);

endmodule

`default_nettype wire

//--- logic/dma_engine.sv
`default_nettype none

module dma_engine (
	input  wire                 clock,
	input  wire                 i_rst_n,
	input  wire                 i_reg_req,
	input  wire bus_pkg::bus_req_t  i_reg_cmd,
	output logic                o_reg_ack,
	output bus_pkg::bus_rsp_t   o_reg_rsp,
	output logic                o_bus_req,
	output bus_pkg::bus_req_t   o_bus_cmd,
	input  wire                 i_bus_ack,
	input  wire bus_pkg::bus_rsp_t  i_bus_rsp
);

	import map_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RD_REQ,
		ST_RD_END,
		ST_WR_REQ,
		ST_WR_END
	} dma_state_t;

	dma_state_t  state;
	logic [31:0] src;
	logic [31:0] dst;
	logic [31:0] count;
	logic        busy;
	logic [31:0] copy_data;
	logic [31:0] ctrl_word;
	logic [1:0]  reg_idx;
	logic        reg_start;

	assign reg_idx   = i_reg_cmd.addr.raw[3:2];
	assign reg_start = i_reg_req && !o_reg_ack;

	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[ctrl_busy_bit] = busy;
	end

	// ====================
	// Registers and copy FSM
	// ====================

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_reg_ack <= 1'b0;
			src       <= '0;
			dst       <= '0;
			count     <= '0;
			busy      <= 1'b0;
			state     <= ST_IDLE;
			o_bus_req <= 1'b0;
		end
		else
		begin
			o_reg_ack <= i_reg_req;

			// Setup locked while a copy runs
			if (reg_start && i_reg_cmd.write && !busy)
			begin
				case (reg_idx)
					dma_reg_src:   src   <= i_reg_cmd.wdata;
					dma_reg_dst:   dst   <= i_reg_cmd.wdata;
					dma_reg_count: count <= i_reg_cmd.wdata;
					dma_reg_ctrl:
						if (i_reg_cmd.wdata[ctrl_start_bit] && count != '0)
							busy <= 1'b1;
					default: ;
				endcase
			end

			case (state)
				ST_IDLE:
					if (busy)
					begin
						o_bus_req <= 1'b1;
						state     <= ST_RD_REQ;
					end
				ST_RD_REQ:
					if (i_bus_ack)
					begin
						o_bus_req <= 1'b0;
						state     <= ST_RD_END;
					end
				ST_RD_END:
					if (!i_bus_ack)
					begin
						o_bus_req <= 1'b1;
						state     <= ST_WR_REQ;
					end
				ST_WR_REQ:
					if (i_bus_ack)
					begin
						o_bus_req <= 1'b0;
						state     <= ST_WR_END;
					end
				ST_WR_END:
					if (!i_bus_ack)
					begin
						src   <= src + 32'd4;
						dst   <= dst + 32'd4;
						count <= count - 32'd1;
						// Last word done
						if (count == 32'd1)
						begin
							busy  <= 1'b0;
							state <= ST_IDLE;
						end
						else
						begin
							o_bus_req <= 1'b1;
							state     <= ST_RD_REQ;
						end
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Word in flight between read and write
	always_ff @(posedge clock)
	begin
		if (state == ST_RD_REQ && i_bus_ack)
			copy_data <= i_bus_rsp.rdata;
	end

	// Register read data, valid with ack
	always_ff @(posedge clock)
	begin
		if (reg_start && !i_reg_cmd.write)
		begin
			case (reg_idx)
				dma_reg_src:   o_reg_rsp.rdata <= src;
				dma_reg_dst:   o_reg_rsp.rdata <= dst;
				dma_reg_count: o_reg_rsp.rdata <= count;
				default:       o_reg_rsp.rdata <= ctrl_word;
			endcase
		end
	end

	always_comb
	begin
		o_bus_cmd.write    = (state == ST_WR_REQ) || (state == ST_WR_END);
		o_bus_cmd.addr.raw = o_bus_cmd.write ? dst : src;
		o_bus_cmd.wdata    = copy_data;
	end

endmodule

`default_nettype wire

//--- logic/block_ram.sv
`default_nettype none

module block_ram #(
	parameter int RAM_WORDS = 512
) (
	input  wire                 clock,
	input  wire                 i_rst_n,
	input  wire                 i_req,
	input  wire bus_pkg::bus_req_t  i_cmd,
	output logic                o_ack,
	output bus_pkg::bus_rsp_t   o_rsp
);

	localparam int AW = $clog2(RAM_WORDS);

	logic [31:0]   mem [RAM_WORDS];
	logic [AW-1:0] idx;
	logic          start;

	// Word index, wraps at the RAM size
	assign idx   = i_cmd.addr.fields.offset[AW+1:2];
	assign start = i_req && !o_ack;

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_ack <= 1'b0;
		else
			o_ack <= i_req;
	end

	// Access once, on the rising edge of ack
	always_ff @(posedge clock)
	begin
		if (start)
		begin
			if (i_cmd.write)
				mem[idx] <= i_cmd.wdata;
			else
				o_rsp.rdata <= mem[idx];
		end
	end

endmodule

`default_nettype wire

//--- logic/bus_decoder.sv
`default_nettype none

module bus_decoder (
	input  wire                 clock,
	input  wire                 i_rst_n,
	input  wire                 i_req,
	input  wire bus_pkg::bus_req_t  i_cmd,
	output logic                o_ack,
	output bus_pkg::bus_rsp_t   o_rsp,
	output logic                o_ram_req,
	input  wire                 i_ram_ack,
	input  wire bus_pkg::bus_rsp_t  i_ram_rsp,
	output logic                o_dma_req,
	input  wire                 i_dma_ack,
	input  wire bus_pkg::bus_rsp_t  i_dma_rsp,
	output bus_pkg::bus_req_t   o_cmd
);

	import map_pkg::*;

	logic sel_ram;
	logic sel_dma;
	logic sel_none;
	logic none_ack;

	assign sel_ram  = i_cmd.addr.fields.region == region_ram;
	assign sel_dma  = i_cmd.addr.fields.region == region_dma;
	assign sel_none = !sel_ram && !sel_dma;

	assign o_ram_req = i_req && sel_ram;
	assign o_dma_req = i_req && sel_dma;
	assign o_cmd     = i_cmd;

	// Unmapped regions answer by themselves
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			none_ack <= 1'b0;
		else
			none_ack <= i_req && sel_none;
	end

	// Only one slave ever saw req, so its ack alone is high.
	// The command may change once req drops, so no region select here.
	assign o_ack = i_ram_ack || i_dma_ack || none_ack;

	always_comb
	begin
		if (i_ram_ack)
			o_rsp = i_ram_rsp;
		else if (i_dma_ack)
			o_rsp = i_dma_rsp;
		else
			o_rsp = '0;
	end

endmodule

`default_nettype wire

//--- logic/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
	input  wire                 clock,
	input  wire                 i_rst_n,
	input  wire                 i_a_req,
	input  wire bus_pkg::bus_addr_t i_a_addr,
	output logic                o_a_ack,
	output bus_pkg::bus_rsp_t   o_a_rsp,
	input  wire                 i_b_req,
	input  wire bus_pkg::bus_req_t  i_b_cmd,
	output logic                o_b_ack,
	output bus_pkg::bus_rsp_t   o_b_rsp,
	input  wire                 i_c_req,
	input  wire bus_pkg::bus_req_t  i_c_cmd,
	output logic                o_c_ack,
	output bus_pkg::bus_rsp_t   o_c_rsp,
	output logic                o_bus_req,
	output bus_pkg::bus_req_t   o_bus_cmd,
	input  wire                 i_bus_ack,
	input  wire bus_pkg::bus_rsp_t  i_bus_rsp
);

	import bus_pkg::*;

	logic [2:0] reqs;
	logic [2:0] grant;
	logic [2:0] pick;
	logic [1:0] last;
	logic       bus_idle;
	bus_req_t   a_cmd;

	assign reqs = {i_c_req, i_b_req, i_a_req};
	assign bus_idle = !o_bus_req && !i_bus_ack;

	// Next requester after the last winner, order a, b, c
	always_comb
	begin
		case (last)
			2'd0:    pick = reqs[1] ? 3'b010 : reqs[2] ? 3'b100 : reqs[0] ? 3'b001 : 3'b000;
			2'd1:    pick = reqs[2] ? 3'b100 : reqs[0] ? 3'b001 : reqs[1] ? 3'b010 : 3'b000;
			default: pick = reqs[0] ? 3'b001 : reqs[1] ? 3'b010 : reqs[2] ? 3'b100 : 3'b000;
		endcase
	end

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			grant     <= 3'b000;
			last      <= 2'd2;
			o_bus_req <= 1'b0;
		end
		else
		begin
			if (grant == 3'b000)
			begin
				if (bus_idle && pick != 3'b000)
				begin
					grant <= pick;
					last  <= pick[1] ? 2'd1 : pick[2] ? 2'd2 : 2'd0;
				end
			end
			// Owner has dropped req on both sides, its ack falls now
			// A new grant still waits for an idle bus
			else if (!(|(grant & reqs)) && !o_bus_req)
				grant <= 3'b000;

			// Downstream req follows the owner one cycle late
			o_bus_req <= |(grant & reqs);
		end
	end

	// Fetch port is always a read
	always_comb
	begin
		a_cmd.write = 1'b0;
		a_cmd.addr  = i_a_addr;
		a_cmd.wdata = '0;
	end

	always_comb
	begin
		case (grant)
			3'b010:  o_bus_cmd = i_b_cmd;
			3'b100:  o_bus_cmd = i_c_cmd;
			default: o_bus_cmd = a_cmd;
		endcase
	end

	// ====================
	// Return path
	// ====================

	assign o_a_ack = grant[0] && i_bus_ack;
	assign o_b_ack = grant[1] && i_bus_ack;
	assign o_c_ack = grant[2] && i_bus_ack;

	assign o_a_rsp = grant[0] ? i_bus_rsp : '0;
	assign o_b_rsp = grant[1] ? i_bus_rsp : '0;
	assign o_c_rsp = grant[2] ? i_bus_rsp : '0;

endmodule

`default_nettype wire

//--- logic/map_pkg.sv
`default_nettype none

package map_pkg;

	// Region codes, top nibble of the address
	localparam logic [3:0] region_ram = 4'h1;
	localparam logic [3:0] region_dma = 4'h9;

	// DMA register index, address bits 3 to 2
	localparam logic [1:0] dma_reg_src   = 2'd0;
	localparam logic [1:0] dma_reg_dst   = 2'd1;
	localparam logic [1:0] dma_reg_count = 2'd2;
	localparam logic [1:0] dma_reg_ctrl  = 2'd3;

	// Control word bits
	localparam int unsigned ctrl_start_bit = 0;
	localparam int unsigned ctrl_busy_bit  = 1;

endpackage

`default_nettype wire

//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// ====================
	// Address word
	// ====================

	// Region in the top nibble, the rest is the offset inside the slave
	typedef struct packed {
		logic [3:0]  region;
		logic [27:0] offset;
	} bus_addr_fields_t;

	typedef union packed {
		logic [31:0]      raw;
		bus_addr_fields_t fields;
	} bus_addr_t;

	// ====================
	// Transfer structs
	// ====================

	typedef struct packed {
		logic        write;
		bus_addr_t   addr;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire
